//--- files.f
+incdir+include
logic/bus_pkg.sv
logic/clock_pkg.sv
logic/bus_req_if.sv
logic/clock_enables.sv
logic/bus_decode.sv
logic/cycle_sequencer.sv
logic/fast_ram.sv
logic/slow_peripheral.sv
logic/bus_response.sv
logic/bbc_bus_core.sv
testbench/tb_bbc_bus_core.sv

//--- include/bus_params.svh
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// Fast RAM bytes, mapped from address 0
`define RAM_DEPTH 1024

// Slow 1 MHz bus window, SHEILA style page
`define SLOW_BASE 16'hFE00

// Registers in the slow window
`define SLOW_SIZE 16'd4

// Data returned for unmapped reads
// Floating bus reads back all ones
`define UNMAPPED_DATA 8'hFF

`endif

//--- logic/bbc_bus_core.sv
`timescale 1ns/1ns
`default_nettype none

module bbc_bus_core import bus_pkg::*; (
   input  logic      clk_32m,
   input  logic      rst,
   input  logic      cyc,
   input  logic      stb,
   input  logic      we,
   input  bus_addr_t adr,
   input  bus_data_t dat_w,
   output logic      ack,
   output bus_data_t dat_r,
   output logic      mhz1_e,
   output logic      phi0
);

   logic        cpu_clken;
   logic        mhz1_enable;
   logic        ram_en;
   logic        slow_en;
   logic        acc_we;
   bus_addr_t   acc_addr;
   bus_data_t   acc_wdata;
   logic        done;
   bus_region_t done_region;
   bus_data_t   ram_rdata;
   bus_data_t   slow_rdata;

   // Decoded request, decode to execute
   bus_req_if req ();

   // Video, tube and faster enables stay inside for now
   // mhz1_e doubles as the internal 1 MHz enable
   clock_enables i_clock_enables (
      .clk_32m     (clk_32m),
      .rst         (rst),
      .mhz1_enable (mhz1_enable),
      .cpu_clken   (cpu_clken),
      .cpu_phi0    (phi0),
      .vid_clken   (),
      .tube_clken  (),
      .mhz4_clken  (),
      .mhz2_clken  (),
      .mhz1_clken  (mhz1_e)
   );

   bus_decode i_bus_decode (
      .clk_32m (clk_32m),
      .rst     (rst),
      .cyc     (cyc),
      .stb     (stb),
      .we      (we),
      .adr     (adr),
      .dat_w   (dat_w),
      .ack     (ack),
      .req     (req.decode)
   );

   cycle_sequencer i_cycle_sequencer (
      .clk_32m     (clk_32m),
      .rst         (rst),
      .req         (req.execute),
      .cpu_clken   (cpu_clken),
      .mhz1_clken  (mhz1_e),
      .mhz1_enable (mhz1_enable),
      .ram_en      (ram_en),
      .slow_en     (slow_en),
      .acc_we      (acc_we),
      .acc_addr    (acc_addr),
      .acc_wdata   (acc_wdata),
      .done        (done),
      .done_region (done_region)
   );

   fast_ram i_fast_ram (
      .clk_32m   (clk_32m),
      .ram_en    (ram_en),
      .acc_we    (acc_we),
      .acc_addr  (acc_addr),
      .acc_wdata (acc_wdata),
      .ram_rdata (ram_rdata)
   );

   slow_peripheral i_slow_peripheral (
      .clk_32m    (clk_32m),
      .rst        (rst),
      .mhz1_clken (mhz1_e),
      .slow_en    (slow_en),
      .acc_we     (acc_we),
      .acc_addr   (acc_addr),
      .acc_wdata  (acc_wdata),
      .slow_rdata (slow_rdata)
   );

   bus_response i_bus_response (
      .clk_32m     (clk_32m),
      .rst         (rst),
      .done        (done),
      .done_region (done_region),
      .ram_rdata   (ram_rdata),
      .slow_rdata  (slow_rdata),
      .ack         (ack),
      .dat_r       (dat_r)
   );

endmodule

`default_nettype wire

//--- logic/bus_decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "bus_params.svh"

module bus_decode import bus_pkg::*; (
   input  logic      clk_32m,
   input  logic      rst,
   input  logic      cyc,
   input  logic      stb,
   input  logic      we,
   input  bus_addr_t adr,
   input  bus_data_t dat_w,
   input  logic      ack,
   bus_req_if.decode req
);

   bus_region_t region_next;
   logic        busy;
   logic        start;

   // Address map
   always_comb begin
      if (adr < 16'(`RAM_DEPTH)) begin
         region_next = REGION_RAM;
      end else if (adr >= `SLOW_BASE && adr < `SLOW_BASE + `SLOW_SIZE) begin
         region_next = REGION_SLOW;
      end else begin
         region_next = REGION_NONE;
      end
   end

   // New transfer, only one in flight
   assign start = cyc && stb && !busy;

   // Busy until ack, valid until the execute stage is done
   always_ff @(posedge clk_32m) begin
      if (rst) begin
         busy      <= 1'b0;
         req.valid <= 1'b0;
      end else if (start) begin
         busy      <= 1'b1;
         req.valid <= 1'b1;
      end else begin
         if (req.done)
            req.valid <= 1'b0;
         if (ack)
            busy <= 1'b0;
      end
   end

   // Request payload
   always_ff @(posedge clk_32m) begin
      if (start) begin
         req.region <= region_next;
         req.addr   <= adr;
         req.wdata  <= dat_w;
         req.we     <= we;
      end
   end

   // Ack only closes a transfer that was accepted here
   a_ack_in_flight: assert property (
      @(posedge clk_32m) disable iff (rst) ack |-> busy
   ) else $error("ack without a transfer in flight");

endmodule

`default_nettype wire

//--- logic/bus_pkg.sv
`timescale 1ns/1ns
`default_nettype none

// Types shared by the Wishbone side, the decode and the execute stages
package bus_pkg;

   // One request address, full 64K map
   typedef logic [15:0] bus_addr_t;

   // One data byte
   typedef logic [7:0] bus_data_t;

   // Where a request lands in the map
   typedef enum logic [1:0] {
      REGION_RAM,
      REGION_SLOW,
      REGION_NONE
   } bus_region_t;

   // Execute stage FSM
   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_WAIT,
      SEQ_DONE
   } seq_state_t;

endpackage

`default_nettype wire

//--- logic/bus_req_if.sv
`timescale 1ns/1ns
`default_nettype none

// One decoded request, decode stage to execute stage
interface bus_req_if import bus_pkg::*; ();

   // Request outstanding at the execute stage
   logic        valid;
   bus_region_t region;
   bus_addr_t   addr;
   bus_data_t   wdata;
   logic        we;

   // Execute stage finished the access
   logic        done;

   modport decode (
      output valid, region, addr, wdata, we,
      input  done
   );

   modport execute (
      input  valid, region, addr, wdata, we,
      output done
   );

endinterface

`default_nettype wire

//--- logic/bus_response.sv
`timescale 1ns/1ns
`default_nettype none
`include "bus_params.svh"

module bus_response import bus_pkg::*; (
   input  logic        clk_32m,
   input  logic        rst,
   input  logic        done,
   input  bus_region_t done_region,
   input  bus_data_t   ram_rdata,
   input  bus_data_t   slow_rdata,
   output logic        ack,
   output bus_data_t   dat_r
);

   bus_region_t region_q;

   // Ack the cycle after the access, when read data is out
   always_ff @(posedge clk_32m) begin
      if (rst) begin
         ack      <= 1'b0;
         region_q <= REGION_NONE;
      end else begin
         ack <= done;
         if (done)
            region_q <= done_region;
      end
   end

   // Read data by region
   always_comb begin
      case (region_q)
         REGION_RAM:  dat_r = ram_rdata;
         REGION_SLOW: dat_r = slow_rdata;
         default:     dat_r = `UNMAPPED_DATA;
      endcase
   end

endmodule

`default_nettype wire

//--- logic/clock_enables.sv
`timescale 1ns/1ns
`default_nettype none

module clock_enables import clock_pkg::*; (
   input  logic clk_32m,
   input  logic rst,
   input  logic mhz1_enable,
   output logic cpu_clken,
   output logic cpu_phi0,
   output logic vid_clken,
   output logic tube_clken,
   output logic mhz4_clken,
   output logic mhz2_clken,
   output logic mhz1_clken
);

   // Free running frame position
   frame_phase_t phase = '0;
   frame_phase_t phase_prev;
   cycle_mask_t  mask;
   logic         cpu_slot;

   // Video on odd phases, 16 MHz
   assign vid_clken  = phase[0];
   // 7, 15, 23, 31
   assign mhz4_clken = &phase[2:0];
   // 15, 31
   assign mhz2_clken = mhz4_clken & phase[3];
   // 31 only
   assign mhz1_clken = mhz2_clken & phase[4];
   // 1, 9, 17, 25
   assign tube_clken = (phase[2:0] == 3'b001);

   // CPU slots at 0 and 16, dropped while stretched
   assign cpu_slot  = (phase[3:0] == 4'd0);
   assign cpu_clken = cpu_slot & (mask == 2'd0);

   // Phi0 high for the half cycle ending on a CPU slot
   assign phase_prev = phase - 5'd1;
   assign cpu_phi0   = phase_prev[3];

   always_ff @(posedge clk_32m) begin
      phase <= phase + 5'd1;
   end

   // 1 MHz cycle stretching
   always_ff @(posedge clk_32m) begin
      if (rst) begin
         mask <= 2'd0;
      end else if (mhz2_clken) begin
         if (mask != 2'd0) begin
            mask <= mask - 2'd1;
         end else if (mhz1_enable) begin
            // Two slots when the 1 MHz edge is right now
            mask <= mhz1_clken ? 2'd2 : 2'd1;
         end
      end
   end

   // CPU and 1 MHz bus never own the same cycle
   a_no_slot_clash: assert property (
      @(posedge clk_32m) !(cpu_clken && mhz1_clken)
   ) else $error("CPU slot and 1 MHz slot in one cycle");

endmodule

`default_nettype wire

//--- logic/clock_pkg.sv
`timescale 1ns/1ns
`default_nettype none

// Types for the 32 phase frame timing
package clock_pkg;

   // Position inside the 1 us frame, 0 to 31
   typedef logic [4:0] frame_phase_t;

   // CPU slots still to suppress
   // 0 means the CPU runs freely
   typedef logic [1:0] cycle_mask_t;

endpackage

`default_nettype wire

//--- logic/cycle_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module cycle_sequencer import bus_pkg::*; (
   input  logic        clk_32m,
   input  logic        rst,
   bus_req_if.execute  req,
   input  logic        cpu_clken,
   input  logic        mhz1_clken,
   output logic        mhz1_enable,
   output logic        ram_en,
   output logic        slow_en,
   output logic        acc_we,
   output bus_addr_t   acc_addr,
   output bus_data_t   acc_wdata,
   output logic        done,
   output bus_region_t done_region
);

   seq_state_t state;
   logic       pending;
   logic       slot_ok;

   // Request waiting for its slot
   assign pending = req.valid && (state != SEQ_DONE);

   // Slot that each region may use
   always_comb begin
      case (req.region)
         REGION_RAM:  slot_ok = cpu_clken;
         REGION_SLOW: slot_ok = mhz1_clken;
         // Unmapped needs no bus slot
         default:     slot_ok = 1'b1;
      endcase
   end

   // One cycle strobes in the slot itself
   assign ram_en  = pending && slot_ok && (req.region == REGION_RAM);
   assign slow_en = pending && slot_ok && (req.region == REGION_SLOW);

   // Ask for the CPU stretch while a 1 MHz access waits
   assign mhz1_enable = pending && (req.region == REGION_SLOW);

   // Done marks the access cycle, ack is registered from it
   assign done        = pending && slot_ok;
   assign req.done    = done;
   assign done_region = req.region;

   assign acc_we    = req.we;
   assign acc_addr  = req.addr;
   assign acc_wdata = req.wdata;

   always_ff @(posedge clk_32m) begin
      if (rst) begin
         state <= SEQ_IDLE;
      end else begin
         case (state)
            SEQ_IDLE:
               if (req.valid)
                  state <= slot_ok ? SEQ_DONE : SEQ_WAIT;
            SEQ_WAIT:
               if (slot_ok)
                  state <= SEQ_DONE;
            // Let valid drop before the next request
            SEQ_DONE: state <= SEQ_IDLE;
            default:  state <= SEQ_IDLE;
         endcase
      end
   end

   a_one_strobe: assert property (
      @(posedge clk_32m) disable iff (rst) $onehot0({ram_en, slow_en})
   ) else $error("RAM and slow strobe together");

   // A request gets exactly one access
   a_strobe_once: assert property (
      @(posedge clk_32m) disable iff (rst)
      (ram_en || slow_en) |=> !(ram_en || slow_en)
   ) else $error("Access strobe repeated");

endmodule

`default_nettype wire

//--- logic/fast_ram.sv
`timescale 1ns/1ns
`default_nettype none
`include "bus_params.svh"

module fast_ram import bus_pkg::*; (
   input  logic      clk_32m,
   input  logic      ram_en,
   input  logic      acc_we,
   input  bus_addr_t acc_addr,
   input  bus_data_t acc_wdata,
   output bus_data_t ram_rdata
);

   localparam int ADDR_W = $clog2(`RAM_DEPTH);

   bus_data_t         mem [`RAM_DEPTH];
   logic [ADDR_W-1:0] index;

   // Decode already limited the address to the RAM range
   assign index = acc_addr[ADDR_W-1:0];

   // Single port, old data out on a write
   always_ff @(posedge clk_32m) begin
      if (ram_en) begin
         if (acc_we)
            mem[index] <= acc_wdata;
         ram_rdata <= mem[index];
      end
   end

endmodule

`default_nettype wire

//--- logic/slow_peripheral.sv
`timescale 1ns/1ns
`default_nettype none

module slow_peripheral import bus_pkg::*; (
   input  logic      clk_32m,
   input  logic      rst,
   input  logic      mhz1_clken,
   input  logic      slow_en,
   input  logic      acc_we,
   input  bus_addr_t acc_addr,
   input  bus_data_t acc_wdata,
   output bus_data_t slow_rdata
);

   bus_data_t  usec_count;
   bus_data_t  latch_1;
   bus_data_t  latch_2;
   logic [1:0] offset;

   // Four registers, mirrored nowhere else
   assign offset = acc_addr[1:0];

   // Microsecond counter, one tick per frame
   always_ff @(posedge clk_32m) begin
      if (rst)
         usec_count <= '0;
      else if (mhz1_clken)
         usec_count <= usec_count + 8'd1;
   end

   // Latches at offsets 1 and 2
   // Offsets 0 and 3 are read only
   always_ff @(posedge clk_32m) begin
      if (slow_en && acc_we) begin
         case (offset)
            2'd1:    latch_1 <= acc_wdata;
            2'd2:    latch_2 <= acc_wdata;
            default: ;
         endcase
      end
   end

   // Read sampled on the access edge
   // Counter value from before this tick
   always_ff @(posedge clk_32m) begin
      if (slow_en) begin
         case (offset)
            2'd0:    slow_rdata <= usec_count;
            2'd1:    slow_rdata <= latch_1;
            2'd2:    slow_rdata <= latch_2;
            default: slow_rdata <= ~latch_1;
         endcase
      end
   end

   // 1 MHz bus accessed only on its own edge
   a_slow_on_edge: assert property (
      @(posedge clk_32m) disable iff (rst) slow_en |-> mhz1_clken
   ) else $error("Slow access outside the 1 MHz slot");

endmodule

`default_nettype wire

//--- testbench/tb_bbc_bus_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "bus_params.svh"

module tb_bbc_bus_core import bus_pkg::*, clock_pkg::*; ();

   localparam int RAM_WORDS = 8;
   // RAM writes and reads, plus slow, unmapped, counter and stretch transfers
   localparam int N_XFERS   = 2 * RAM_WORDS + 17;
   // 40 cycles per transfer, margin for reset, sync and phase waits
   localparam int TIMEOUT   = 40 * N_XFERS + 300;

   logic      clk_32m;
   logic      rst;
   logic      cyc;
   logic      stb;
   logic      we;
   bus_addr_t adr;
   bus_data_t dat_w;
   logic      ack;
   bus_data_t dat_r;
   logic      mhz1_e;
   logic      phi0;

   integer seed = 32'h1dd3f096;
   int     errors = 0;
   int     transfers = 0;
   int     cycles = 0;

   // Frame phase seen from outside, synced on mhz1_e
   frame_phase_t tb_phase = '0;
   logic         phase_known = 1'b0;
   int           pulse_count = 0;
   int           lat_count = 0;

   // Transfer in flight, read by the assertions
   string        test_name = "";
   bus_region_t  xfer_region = REGION_NONE;
   int           max_lat = 0;
   logic         data_chk = 1'b0;
   bus_data_t    exp_data = '0;
   logic         cnt_first = 1'b0;
   logic         cnt_chk = 1'b0;
   bus_data_t    cnt_base = '0;
   int           pulse_base = 0;
   logic         ram_phase_chk = 1'b0;
   frame_phase_t ram_phase_exp = '0;

   // Reference RAM
   bus_data_t ram_model [`RAM_DEPTH];
   bus_addr_t ram_addrs [$];

   bbc_bus_core i_bbc_bus_core (
      .clk_32m (clk_32m),
      .rst     (rst),
      .cyc     (cyc),
      .stb     (stb),
      .we      (we),
      .adr     (adr),
      .dat_w   (dat_w),
      .ack     (ack),
      .dat_r   (dat_r),
      .mhz1_e  (mhz1_e),
      .phi0    (phi0)
   );

   initial begin
      clk_32m = 1'b0;
      forever #4 clk_32m = ~clk_32m;
   end

   // Phase 31 carries mhz1_e, so the next cycle is phase 0
   always @(posedge clk_32m) begin
      if (mhz1_e) begin
         tb_phase    <= '0;
         phase_known <= 1'b1;
      end else begin
         tb_phase <= tb_phase + 5'd1;
      end
      // 1 MHz pulses seen since reset
      if (rst)
         pulse_count <= 0;
      else if (mhz1_e)
         pulse_count <= pulse_count + 1;
      // Counter value and pulse count at the first counter ack
      if (ack && cnt_first) begin
         cnt_base   <= dat_r;
         pulse_base <= pulse_count;
      end
      // Cycles since stb rose
      if (!stb)
         lat_count <= 0;
      else
         lat_count <= lat_count + 1;
   end

   always @(posedge clk_32m) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("Timeout after %0d cycles, a transfer never completed", cycles);
         $display("Transfers: %0d, errors: %0d", transfers, errors);
         $display("Testbench failed");
         $finish;
      end
   end

   // Phi0 high for the eight cycles up to and including each CPU slot
   function automatic logic phi0_high(input frame_phase_t p);
      return (p >= 5'd9 && p <= 5'd16) || p >= 5'd25 || p == 5'd0;
   endfunction

   a_read_data: assert property (
      @(posedge clk_32m) disable iff (rst) (ack && data_chk) |-> dat_r == exp_data
   ) else begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", test_name,
               $sampled(exp_data), $sampled(dat_r));
   end

   // Counter moved by the 1 MHz pulses between the two acks
   a_counter: assert property (
      @(posedge clk_32m) disable iff (rst)
      (ack && cnt_chk) |-> dat_r == 8'(cnt_base + (pulse_count - pulse_base))
   ) else begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", test_name,
               8'($sampled(cnt_base) + ($sampled(pulse_count) - $sampled(pulse_base))),
               $sampled(dat_r));
   end

   // One 1 MHz pulse per frame, always at phase 31
   a_mhz1_period: assert property (
      @(posedge clk_32m) phase_known |-> mhz1_e == (tb_phase == 5'd31)
   ) else begin
      errors++;
      $display("FAILED mhz1_period: expected %b, actual %b",
               $sampled(tb_phase) == 5'd31, $sampled(mhz1_e));
   end

   a_phi0: assert property (
      @(posedge clk_32m) phase_known |-> phi0 == phi0_high(tb_phase)
   ) else begin
      errors++;
      $display("FAILED phi0_timing: expected %b, actual %b",
               phi0_high($sampled(tb_phase)), $sampled(phi0));
   end

   a_ram_phase: assert property (
      @(posedge clk_32m) disable iff (rst || !phase_known)
      (ack && xfer_region == REGION_RAM) |-> (tb_phase == 5'd1 || tb_phase == 5'd17)
   ) else begin
      errors++;
      $display("FAILED %s: expected phase 1 or 17, actual %0d", test_name,
               $sampled(tb_phase));
   end

   a_slow_phase: assert property (
      @(posedge clk_32m) disable iff (rst || !phase_known)
      (ack && xfer_region == REGION_SLOW) |-> tb_phase == 5'd0
   ) else begin
      errors++;
      $display("FAILED %s: expected phase 0, actual %0d", test_name, $sampled(tb_phase));
   end

   // RAM slot left after the 1 MHz stretch
   a_stretch_phase: assert property (
      @(posedge clk_32m) disable iff (rst || !phase_known)
      (ack && ram_phase_chk) |-> tb_phase == ram_phase_exp
   ) else begin
      errors++;
      $display("FAILED %s: expected phase %0d, actual %0d", test_name,
               $sampled(ram_phase_exp), $sampled(tb_phase));
   end

   a_ack_single: assert property (
      @(posedge clk_32m) disable iff (rst) ack |=> !ack
   ) else begin
      errors++;
      $display("ack stayed high for more than one cycle in %s", test_name);
   end

   a_reset_quiet: assert property (
      @(posedge clk_32m) rst |=> !ack
   ) else begin
      errors++;
      $display("ack went high during or right after reset");
   end

   a_latency: assert property (
      @(posedge clk_32m) disable iff (rst) stb |-> lat_count <= max_lat
   ) else begin
      errors++;
      $display("%s took more than %0d cycles to ack", test_name, max_lat);
   end

   // Address map
   function automatic bus_region_t region_of(input bus_addr_t addr);
      if (addr < `RAM_DEPTH)
         return REGION_RAM;
      if (addr >= `SLOW_BASE && addr < `SLOW_BASE + `SLOW_SIZE)
         return REGION_SLOW;
      return REGION_NONE;
   endfunction

   // Worst case from the first stb cycle to ack
   function automatic int latency_limit(input bus_region_t region);
      case (region)
         REGION_RAM:  return 34;
         REGION_SLOW: return 33;
         default:     return 2;
      endcase
   endfunction

   // One Wishbone classic transfer, held until ack
   task automatic transfer(input string name, input logic write, input bus_addr_t addr,
                           input bus_data_t wdata, input logic check,
                           input bus_data_t expected);
      @(posedge clk_32m);
      test_name   <= name;
      xfer_region <= region_of(addr);
      max_lat     <= latency_limit(region_of(addr));
      data_chk    <= check;
      exp_data    <= expected;
      cyc         <= 1'b1;
      stb         <= 1'b1;
      we          <= write;
      adr         <= addr;
      dat_w       <= wdata;
      // Mid cycle, ack and data settled
      do
         @(negedge clk_32m);
      while (!ack);
      // stb low in the cycle after ack
      @(posedge clk_32m);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
      transfers++;
   endtask

   task automatic read_expect(input string name, input bus_addr_t addr,
                              input bus_data_t expected);
      transfer(name, 1'b0, addr, '0, 1'b1, expected);
   endtask

   task automatic write_only(input string name, input bus_addr_t addr, input bus_data_t data);
      transfer(name, 1'b1, addr, data, 1'b0, '0);
   endtask

   task automatic ram_write(input bus_addr_t addr, input bus_data_t data);
      ram_model[addr] = data;
      write_only("ram_write", addr, data);
   endtask

   // First read sets the base for the second
   task automatic counter_read(input string name, input logic first);
      cnt_first <= first;
      cnt_chk   <= !first;
      transfer(name, 1'b0, `SLOW_BASE, '0, 1'b0, '0);
      cnt_first <= 1'b0;
      cnt_chk   <= 1'b0;
   endtask

   // Returns just after the edge that ends phase p
   task automatic wait_phase(input frame_phase_t p);
      do
         @(posedge clk_32m);
      while (tb_phase != p);
   endtask

   // Slow read with stb from phase p + 2, then a RAM read right behind it
   task automatic stretch_pair(input string name, input frame_phase_t p,
                               input bus_data_t slow_exp, input frame_phase_t ram_ack);
      wait_phase(p);
      read_expect(name, `SLOW_BASE + 16'd2, slow_exp);
      ram_phase_chk <= 1'b1;
      ram_phase_exp <= ram_ack;
      read_expect(name, ram_addrs[0], ram_model[ram_addrs[0]]);
      ram_phase_chk <= 1'b0;
   endtask

   initial begin
      bus_addr_t addr;
      bus_data_t latch_1_val;
      bus_data_t latch_2_val;
      int        gap;

      rst   = 1'b1;
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      adr   = '0;
      dat_w = '0;
      repeat (3) @(posedge clk_32m);
      rst <= 1'b0;
      // Phase unknown until the first 1 MHz pulse
      while (!phase_known)
         @(posedge clk_32m);

      // Fast RAM round trip
      for (int i = 0; i < RAM_WORDS; i++) begin
         addr = bus_addr_t'($random(seed)) & bus_addr_t'(`RAM_DEPTH - 1);
         ram_addrs.push_back(addr);
         ram_write(addr, bus_data_t'($random(seed)));
      end
      foreach (ram_addrs[i]) begin
         read_expect("ram_read", ram_addrs[i], ram_model[ram_addrs[i]]);
      end

      // Latches, inverse readback, ignored writes
      latch_1_val = bus_data_t'($random(seed));
      latch_2_val = bus_data_t'($random(seed));
      write_only("latch_1_write", `SLOW_BASE + 16'd1, latch_1_val);
      write_only("latch_2_write", `SLOW_BASE + 16'd2, latch_2_val);
      read_expect("latch_1_read", `SLOW_BASE + 16'd1, latch_1_val);
      read_expect("latch_2_read", `SLOW_BASE + 16'd2, latch_2_val);
      read_expect("inverse_read", `SLOW_BASE + 16'd3, ~latch_1_val);
      write_only("inverse_write", `SLOW_BASE + 16'd3, bus_data_t'($random(seed)));
      read_expect("inverse_reread", `SLOW_BASE + 16'd3, ~latch_1_val);

      // Unmapped space floats high
      for (int i = 0; i < 2; i++) begin
         addr = 16'h0400 + (bus_addr_t'($random(seed)) & 16'h7FFF);
         read_expect("unmapped_read", addr, 8'hFF);
      end
      write_only("unmapped_write", 16'h8000, bus_data_t'($random(seed)));

      // Counter advances by the pulses between the two acks
      counter_read("counter_first", 1'b1);
      // Offset 0 ignores writes
      write_only("counter_write", `SLOW_BASE, bus_data_t'($random(seed)));
      gap = 40 + ($unsigned($random(seed)) % 64);
      repeat (gap) @(posedge clk_32m);
      counter_read("counter_second", 1'b0);

      // Slow pending at phase 15, only slot 16 of its own frame is lost
      stretch_pair("stretch_one", 5'd2, latch_2_val, 5'd17);
      // Stretch set at phase 31 hides slots 0 and 16
      stretch_pair("stretch_two", 5'd18, latch_2_val, 5'd1);

      repeat (4) @(posedge clk_32m);
      $display("Transfers: %0d, errors: %0d", transfers, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire
